// File: design/rx_buffer_pkg.sv
/*
 * shared types of the rx sample buffer path
 * referenced by scoped name from every block and from the testbench
 */
`include "rx_buffer_consts.svh"

package rx_buffer_pkg;

	typedef logic [`RX_WORD_W-1:0] rx_word_t;			// one buffer word
	typedef logic [`RX_BUF_AW-1:0] rx_addr_t;			// buffer address, wraps
	typedef logic [`RX_NSAMPS_W-1:0] rx_nsamps_t;		// sample sets per block
	typedef logic [`RX_TICKS_W-1:0] rx_ticks_t;			// timestamp
	typedef logic [$clog2(`RX_CHANS+1)-1:0] rx_chan_t;	// wide enough to hold RX_CHANS itself

	// one channel's sample set, i in the top bits
	typedef struct packed {
		rx_word_t i;
		rx_word_t q;
		rx_word_t iq3;
	} rx_sample_t;

	typedef rx_sample_t [`RX_CHANS-1:0] rx_sample_vec_t;	// element 0 is channel 0

	// one-hot word kind within a channel
	// also picks the tick word: sel_i low, sel_q mid, sel_iq3 high
	typedef enum logic [2:0] {
		sel_i   = 3'b001,
		sel_q   = 3'b010,
		sel_iq3 = 3'b100
	} rx_word_sel_t;

	// write control, registered in the fsm and aligned with the write strobe
	typedef struct packed {
		logic wr;				// write one word, then advance the write address
		rx_chan_t chan;			// source channel when moving samples
		rx_word_sel_t word;		// sample word or tick word
		logic use_ts;			// write a tick word
		logic use_ctr;			// write the buffer count
	} rx_xfer_ctl_t;

	typedef enum logic [2:0] {xs_idle, xs_chan, xs_ticks, xs_ctr, xs_done} rx_xfer_state_t;

endpackage

// File: design/rx_buffer_top.sv
/*
 * shared rx sample buffer path: transfer fsm, word select, buffer memory and host port
 * everything runs on adc_clk, host commands arrive as single-cycle strobes
 */
`timescale 1ns/1ps

module rx_buffer_top (
	input  logic                          adc_clk,
	input  logic                          reset_bufs_A,
	input  logic                          rx_avail_i,
	input  rx_buffer_pkg::rx_sample_vec_t samples_i,
	input  rx_buffer_pkg::rx_ticks_t      ticks_i,
	input  logic                          set_nsamps_i,
	input  rx_buffer_pkg::rx_nsamps_t     host_data_i,
	input  logic                          get_rx_srq_i,
	input  logic                          get_rx_samp_i,
	input  logic                          get_buf_ctr_i,
	output logic                          rx_rd_o,
	output rx_buffer_pkg::rx_word_t       rx_dout_o,
	output logic                          ser_o
);

	rx_buffer_pkg::rx_xfer_ctl_t xfer_ctl;
	rx_buffer_pkg::rx_nsamps_t   nsamps;
	rx_buffer_pkg::rx_word_t     din;		// word being written
	rx_buffer_pkg::rx_word_t     buf_ctr;
	rx_buffer_pkg::rx_word_t     buf_word;	// registered buffer read data
	logic                        inc;		// block done
	logic                        buf_rd;

	rx_xfer_fsm xfer_fsm0 (
		.adc_clk      (adc_clk),
		.reset_bufs_A (reset_bufs_A),
		.rx_avail_i   (rx_avail_i),
		.nsamps_i     (nsamps),
		.xfer_ctl_o   (xfer_ctl),
		.inc_o        (inc)
	);

	rx_word_mux word_mux0 (
		.adc_clk      (adc_clk),
		.reset_bufs_A (reset_bufs_A),
		.rx_avail_i   (rx_avail_i),
		.samples_i    (samples_i),
		.ticks_i      (ticks_i),
		.xfer_ctl_i   (xfer_ctl),
		.inc_i        (inc),
		.din_o        (din),
		.buf_ctr_o    (buf_ctr)
	);

	rx_sample_buf sample_buf0 (
		.adc_clk      (adc_clk),
		.reset_bufs_A (reset_bufs_A),
		.wr_i         (xfer_ctl.wr),
		.din_i        (din),
		.rd_i         (buf_rd),
		.dout_o       (buf_word)
	);

	rx_host_port host_port0 (
		.adc_clk       (adc_clk),
		.reset_bufs_A  (reset_bufs_A),
		.set_nsamps_i  (set_nsamps_i),
		.host_data_i   (host_data_i),
		.get_rx_srq_i  (get_rx_srq_i),
		.get_rx_samp_i (get_rx_samp_i),
		.get_buf_ctr_i (get_buf_ctr_i),
		.inc_i         (inc),
		.buf_word_i    (buf_word),
		.buf_ctr_i     (buf_ctr),
		.nsamps_o      (nsamps),
		.buf_rd_o      (buf_rd),
		.rx_rd_o       (rx_rd_o),
		.rx_dout_o     (rx_dout_o),
		.ser_o         (ser_o)
	);

endmodule

// File: design/rx_host_port.sv
/*
 * host side of the buffer: samples-per-block register, service request and
 * read data, returning a buffer word or the buffer count
 */
`timescale 1ns/1ps

module rx_host_port (
	input  logic                      adc_clk,
	input  logic                      reset_bufs_A,
	input  logic                      set_nsamps_i,
	input  rx_buffer_pkg::rx_nsamps_t host_data_i,
	input  logic                      get_rx_srq_i,		// poll service request
	input  logic                      get_rx_samp_i,	// read next buffer word
	input  logic                      get_buf_ctr_i,	// read buffer count
	input  logic                      inc_i,
	input  rx_buffer_pkg::rx_word_t   buf_word_i,
	input  rx_buffer_pkg::rx_word_t   buf_ctr_i,
	output rx_buffer_pkg::rx_nsamps_t nsamps_o,
	output logic                      buf_rd_o,
	output logic                      rx_rd_o,
	output rx_buffer_pkg::rx_word_t   rx_dout_o,
	output logic                      ser_o
);

	rx_buffer_pkg::rx_nsamps_t nsamps_q;
	rx_buffer_pkg::rx_word_t   ctr_q;		// count captured at the read strobe
	logic                      sel_ctr_q;	// last read was the count
	logic                      noted_q;
	logic                      ser_q;
	logic                      rd_q;

	// config register, kept across a buffer reset
	always_ff @(posedge adc_clk)
	begin
		if (set_nsamps_i)
			nsamps_q <= host_data_i;
		if (get_buf_ctr_i)
			ctr_q <= buf_ctr_i;
	end

	always_ff @(posedge adc_clk)
	begin
		if (reset_bufs_A)
		begin
			noted_q   <= 1'b0;
			ser_q     <= 1'b0;
			rd_q      <= 1'b0;
			sel_ctr_q <= 1'b0;
		end
		else
		begin
			if (get_rx_srq_i)
			begin
				ser_q   <= noted_q;
				noted_q <= inc_i;		// a block finishing right now is not lost
			end
			else
				noted_q <= noted_q | inc_i;
			rd_q <= get_rx_samp_i | get_buf_ctr_i;
			if (get_buf_ctr_i)
				sel_ctr_q <= 1'b1;
			else if (get_rx_samp_i)
				sel_ctr_q <= 1'b0;
		end
	end

	assign buf_rd_o  = get_rx_samp_i;		// buffer registers the word itself
	assign nsamps_o  = nsamps_q;
	assign rx_rd_o   = rd_q;
	assign ser_o     = ser_q;
	assign rx_dout_o = sel_ctr_q ? ctr_q : buf_word_i;

endmodule

// File: design/rx_sample_buf.sv
/*
 * 8k x 16 simple dual-port buffer, written by the transfer fsm and read by the host
 * both address counters just wrap, nothing guards against overrun
 */
`timescale 1ns/1ps
`include "rx_buffer_consts.svh"

module rx_sample_buf (
	input  logic                    adc_clk,
	input  logic                    reset_bufs_A,
	input  logic                    wr_i,		// one word per strobe
	input  rx_buffer_pkg::rx_word_t din_i,
	input  logic                    rd_i,		// host read strobe
	output rx_buffer_pkg::rx_word_t dout_o		// held until the next read
);

	rx_buffer_pkg::rx_word_t mem [2**`RX_BUF_AW];
	rx_buffer_pkg::rx_addr_t waddr_q;
	rx_buffer_pkg::rx_addr_t raddr_q;
	rx_buffer_pkg::rx_word_t dout_q;

	// write side
	always_ff @(posedge adc_clk)
	begin
		if (wr_i)
			mem[waddr_q] <= din_i;
	end

	// read side, registered output
	always_ff @(posedge adc_clk)
	begin
		if (rd_i)
			dout_q <= mem[raddr_q];
	end

	// address counters
	always_ff @(posedge adc_clk)
	begin
		if (reset_bufs_A)
		begin
			waddr_q <= '0;
			raddr_q <= '0;
		end
		else
		begin
			waddr_q <= waddr_q + rx_buffer_pkg::rx_addr_t'(wr_i);
			raddr_q <= raddr_q + rx_buffer_pkg::rx_addr_t'(rd_i);
		end
	end

	assign dout_o = dout_q;

endmodule

// File: design/rx_word_mux.sv
/*
 * holds the channel samples and ticks of the current sample set and the buffer count,
 * and picks the word that the fsm is writing into the buffer
 */
`timescale 1ns/1ps
`include "rx_buffer_consts.svh"

module rx_word_mux (
	input  logic                        adc_clk,
	input  logic                        reset_bufs_A,
	input  logic                        rx_avail_i,
	input  rx_buffer_pkg::rx_sample_vec_t samples_i,
	input  rx_buffer_pkg::rx_ticks_t    ticks_i,
	input  rx_buffer_pkg::rx_xfer_ctl_t xfer_ctl_i,
	input  logic                        inc_i,
	output rx_buffer_pkg::rx_word_t     din_o,		// word to write
	output rx_buffer_pkg::rx_word_t     buf_ctr_o	// completed blocks
);

	rx_buffer_pkg::rx_sample_vec_t samples_q;
	logic [`RX_WORDS_PER_CHAN-1:0][`RX_WORD_W-1:0] ticks_q;	// [0] is the low word
	rx_buffer_pkg::rx_word_t       buf_ctr_q;
	rx_buffer_pkg::rx_sample_t     samp;
	rx_buffer_pkg::rx_word_t       chan_word;
	rx_buffer_pkg::rx_word_t       tick_word;

	// stays stable until the next avail, well after the last write of the set
	always_ff @(posedge adc_clk)
	begin
		if (rx_avail_i)
		begin
			samples_q <= samples_i;
			ticks_q   <= ticks_i;
		end
	end

	// buffer count, bumped once per finished block
	always_ff @(posedge adc_clk)
	begin
		if (reset_bufs_A)
			buf_ctr_q <= '0;
		else if (inc_i)
			buf_ctr_q <= buf_ctr_q + 1'b1;
	end

	//////////////////////
	// write data select
	//////////////////////

	always_comb
	begin
		samp      = samples_q[xfer_ctl_i.chan];
		chan_word = samp.i;
		tick_word = ticks_q[0];
		case (xfer_ctl_i.word)
			rx_buffer_pkg::sel_q:
			begin
				chan_word = samp.q;
				tick_word = ticks_q[1];		// mid
			end
			rx_buffer_pkg::sel_iq3:
			begin
				chan_word = samp.iq3;
				tick_word = ticks_q[2];		// high
			end
			default: ;		// i and low tick word
		endcase
	end

	assign din_o = xfer_ctl_i.use_ts ? tick_word :
		(xfer_ctl_i.use_ctr ? buf_ctr_q : chan_word);

	assign buf_ctr_o = buf_ctr_q;

endmodule

// File: design/rx_xfer_fsm.sv
/*
 * sequences the interleaved buffer writes of each sample set and closes a block
 * with three tick words, the buffer count word and a one-cycle inc pulse
 */
`timescale 1ns/1ps
`include "rx_buffer_consts.svh"

module rx_xfer_fsm (
	input  logic                       adc_clk,
	input  logic                       reset_bufs_A,
	input  logic                       rx_avail_i,		// one pulse per sample set
	input  rx_buffer_pkg::rx_nsamps_t  nsamps_i,		// sample sets per block
	output rx_buffer_pkg::rx_xfer_ctl_t xfer_ctl_o,
	output logic                       inc_o			// block finished
);

	// no write, all selects at rest
	localparam rx_buffer_pkg::rx_xfer_ctl_t CTL_IDLE = '{
		wr:      1'b0,
		chan:    '0,
		word:    rx_buffer_pkg::sel_i,
		use_ts:  1'b0,
		use_ctr: 1'b0
	};

	localparam rx_buffer_pkg::rx_chan_t LAST_CHAN = rx_buffer_pkg::rx_chan_t'(`RX_CHANS - 1);

	rx_buffer_pkg::rx_xfer_state_t state_q;
	rx_buffer_pkg::rx_nsamps_t     count_q;		// sample set within the block
	rx_buffer_pkg::rx_chan_t       chan_q;
	rx_buffer_pkg::rx_word_sel_t   word_q;		// word within channel, or tick word
	rx_buffer_pkg::rx_xfer_ctl_t   ctl_q;
	logic                          inc_q;
	logic                          last_samp;
	logic                          last_word;

	// i -> q -> iq3 -> i
	function automatic rx_buffer_pkg::rx_word_sel_t next_word(rx_buffer_pkg::rx_word_sel_t w);
		case (w)
			rx_buffer_pkg::sel_i: return rx_buffer_pkg::sel_q;
			rx_buffer_pkg::sel_q: return rx_buffer_pkg::sel_iq3;
			default:              return rx_buffer_pkg::sel_i;
		endcase
	endfunction

	assign last_samp = (count_q == rx_buffer_pkg::rx_nsamps_t'(nsamps_i - 1'b1));
	assign last_word = (word_q == rx_buffer_pkg::sel_iq3);

	//////////////////////
	// transfer sequencer
	//////////////////////

	always_ff @(posedge adc_clk)
	begin
		if (reset_bufs_A)
		begin
			state_q <= rx_buffer_pkg::xs_idle;
			count_q <= '0;
			chan_q  <= '0;
			word_q  <= rx_buffer_pkg::sel_i;
			ctl_q   <= CTL_IDLE;
			inc_q   <= 1'b0;
		end
		else
		begin
			ctl_q <= CTL_IDLE;		// writes only where a state asks for one
			inc_q <= 1'b0;
			case (state_q)
				rx_buffer_pkg::xs_idle:
				begin
					chan_q <= '0;
					word_q <= rx_buffer_pkg::sel_i;
					if (rx_avail_i)
						state_q <= rx_buffer_pkg::xs_chan;	// first write lands one cycle later
				end

				// 12 back to back channel words
				rx_buffer_pkg::xs_chan:
				begin
					ctl_q <= '{wr: 1'b1, chan: chan_q, word: word_q, use_ts: 1'b0, use_ctr: 1'b0};
					word_q <= next_word(word_q);
					if (last_word)
					begin
						if (chan_q == LAST_CHAN)
						begin
							chan_q <= '0;
							if (last_samp)
							begin
								count_q <= '0;
								state_q <= rx_buffer_pkg::xs_ticks;		// no gap before the ticks
							end
							else
							begin
								count_q <= count_q + 1'b1;
								state_q <= rx_buffer_pkg::xs_idle;		// wait for next sample set
							end
						end
						else
							chan_q <= chan_q + 1'b1;
					end
				end

				// ticks latched at the last avail, low word first
				rx_buffer_pkg::xs_ticks:
				begin
					ctl_q <= '{wr: 1'b1, chan: '0, word: word_q, use_ts: 1'b1, use_ctr: 1'b0};
					word_q <= next_word(word_q);
					if (last_word)
						state_q <= rx_buffer_pkg::xs_ctr;
				end

				rx_buffer_pkg::xs_ctr:
				begin
					ctl_q <= '{wr: 1'b1, chan: '0, word: rx_buffer_pkg::sel_i, use_ts: 1'b0,
						use_ctr: 1'b1};		// count before its increment
					state_q <= rx_buffer_pkg::xs_done;
				end

				// ctr word is being written this cycle, inc follows it
				rx_buffer_pkg::xs_done:
				begin
					inc_q   <= 1'b1;
					state_q <= rx_buffer_pkg::xs_idle;
				end

				default: state_q <= rx_buffer_pkg::xs_idle;
			endcase
		end
	end

	assign xfer_ctl_o = ctl_q;
	assign inc_o      = inc_q;

endmodule

// File: dv/rx_buffer_golden.txt
# test <name> | nsamps <n> | reset | block <count word> | ctr <count> | srq <ser_o after poll>
# avail <ticks, 12 hex> <ch0> <ch1> <ch2> <ch3>, each channel 12 hex as {i, q, iq3}
test one_block
srq 0
nsamps 1
avail 0001a2b3c4d5 110111021103 111111121113 112111221123 113111321133
block 0000
srq 1
srq 0
test multi_block
nsamps 3
avail 0002000000f0 210121022103 211121122113 212121222123 213121322133
avail 0002000001e0 220122022203 221122122213 222122222223 223122322233
avail 7fff8000ffff 230123022303 231123122313 232123222323 233123322333
block 0001
test buf_count
ctr 0002
srq 1
srq 0
test reset
avail 000300000100 310131023103 311131123113 312131223123 313131323133
reset
ctr 0000
srq 0
nsamps 1
avail 0004deadbeef 410141024103 411141124113 412141224123 413141324133
block 0000
ctr 0001
srq 1
srq 0

// File: include/rx_buffer_tb_checks.svh
/*
 * typed compare tasks for the buffer testbench, included inside the testbench module
 * a mismatch prints an error line with the test name and ends the run
 */
`ifndef RX_BUFFER_TB_CHECKS_SVH
`define RX_BUFFER_TB_CHECKS_SVH

// error line, then stop the run
task automatic stop_on_error(input string why);
	n_errors++;
	$display("%s", why);
	$display("Checks failed");
	$fatal(1, "stopping at the first error");
endtask

// one buffer or count word
task automatic check_word(input string what, input rx_buffer_pkg::rx_word_t exp,
	input rx_buffer_pkg::rx_word_t act);
	if (act !== exp)
		stop_on_error($sformatf("ERROR %s %s expected %h actual %h",
			test_name, what, exp, act));
endtask

// single flags such as ser_o and rx_rd_o
task automatic check_bit(input string what, input logic exp, input logic act);
	if (act !== exp)
		stop_on_error($sformatf("ERROR %s %s expected %b actual %b",
			test_name, what, exp, act));
endtask

`endif

// File: dv/rx_buffer_tb.sv
/*
 * testbench for the rx buffer path, replays the golden record file against the DUT
 * and checks buffer words, buffer count and service request as each record runs
 */
`timescale 1ns/1ps
`include "rx_buffer_consts.svh"

module rx_buffer_tb;

	logic                          adc_clk = 1'b0;
	logic                          reset_bufs_A;
	logic                          rx_avail_i;
	rx_buffer_pkg::rx_sample_vec_t samples_i;
	rx_buffer_pkg::rx_ticks_t      ticks_i;
	logic                          set_nsamps_i;
	rx_buffer_pkg::rx_nsamps_t     host_data_i;
	logic                          get_rx_srq_i;
	logic                          get_rx_samp_i;
	logic                          get_buf_ctr_i;
	logic                          rx_rd_o;
	rx_buffer_pkg::rx_word_t       rx_dout_o;
	logic                          ser_o;

	string                         test_name = "none";
	string                         recs[$];		// golden lines, comments dropped
	rx_buffer_pkg::rx_sample_vec_t sets[$];		// sample sets of the open block
	rx_buffer_pkg::rx_ticks_t      last_ticks;	// ticks of the latest avail
	logic                          ser_last = 1'b0;	// ser_o as of the last poll
	int unsigned                   n_errors = 0;
	int unsigned                   limit_cycles = 0;

	rx_buffer_top dut0 (
		.adc_clk       (adc_clk),
		.reset_bufs_A  (reset_bufs_A),
		.rx_avail_i    (rx_avail_i),
		.samples_i     (samples_i),
		.ticks_i       (ticks_i),
		.set_nsamps_i  (set_nsamps_i),
		.host_data_i   (host_data_i),
		.get_rx_srq_i  (get_rx_srq_i),
		.get_rx_samp_i (get_rx_samp_i),
		.get_buf_ctr_i (get_buf_ctr_i),
		.rx_rd_o       (rx_rd_o),
		.rx_dout_o     (rx_dout_o),
		.ser_o         (ser_o)
	);

	always #2 adc_clk = ~adc_clk;		// 4 ns period

	////////////////////
	// checks
	////////////////////

	`include "rx_buffer_tb_checks.svh"

	////////////////////
	// host and sample drivers
	////////////////////

	// all drive on the falling edge, results looked at one falling edge later
	task automatic read_word(input rx_buffer_pkg::rx_word_t exp, input string what);
		@(negedge adc_clk);
		check_bit("rx_rd_o idle", 1'b0, rx_rd_o);	// no strobe in the cycle before
		get_rx_samp_i = 1'b1;
		@(negedge adc_clk);
		get_rx_samp_i = 1'b0;
		check_bit("rx_rd_o", 1'b1, rx_rd_o);		// high in the cycle after the strobe
		check_word(what, exp, rx_dout_o);
	endtask

	task automatic read_ctr(input rx_buffer_pkg::rx_word_t exp);
		@(negedge adc_clk);
		check_bit("rx_rd_o idle", 1'b0, rx_rd_o);
		get_buf_ctr_i = 1'b1;
		@(negedge adc_clk);
		get_buf_ctr_i = 1'b0;
		check_bit("rx_rd_o", 1'b1, rx_rd_o);
		check_word("buffer count", exp, rx_dout_o);
	endtask

	task automatic poll_srq(input logic exp);
		check_bit("ser_o before poll", ser_last, ser_o);	// holds between polls
		@(negedge adc_clk);
		get_rx_srq_i = 1'b1;
		@(negedge adc_clk);
		get_rx_srq_i = 1'b0;
		check_bit("ser_o", exp, ser_o);
		ser_last = exp;
	endtask

	task automatic set_block_size(input rx_buffer_pkg::rx_nsamps_t n);
		@(negedge adc_clk);
		set_nsamps_i = 1'b1;
		host_data_i  = n;
		@(negedge adc_clk);
		set_nsamps_i = 1'b0;
	endtask

	// one sample set, then an idle gap long enough for the block's writes
	task automatic pulse_avail(input rx_buffer_pkg::rx_ticks_t tk,
		input rx_buffer_pkg::rx_sample_vec_t sv);
		int unsigned gap;
		gap = 24 + ($urandom % 17);
		@(negedge adc_clk);
		rx_avail_i = 1'b1;
		samples_i  = sv;
		ticks_i    = tk;
		@(negedge adc_clk);
		rx_avail_i = 1'b0;
		samples_i  = ~sv;		// must not leak into the block
		ticks_i    = ~tk;
		repeat (gap) @(negedge adc_clk);
		sets.push_back(sv);
		last_ticks = tk;
	endtask

	task automatic apply_reset;
		@(negedge adc_clk);
		reset_bufs_A = 1'b1;
		repeat (10) @(negedge adc_clk);
		reset_bufs_A = 1'b0;
		sets.delete();
		ser_last = 1'b0;
	endtask

	// block rule: ch0..ch3 i q iq3 per set, ticks low mid high, then the count word
	task automatic read_block(input rx_buffer_pkg::rx_word_t exp_ctr);
		rx_buffer_pkg::rx_sample_vec_t sv;
		while (sets.size() > 0)
		begin
			sv = sets.pop_front();
			for (int c = 0; c < `RX_CHANS; c++)
			begin
				read_word(sv[c].i, $sformatf("ch%0d i", c));
				read_word(sv[c].q, $sformatf("ch%0d q", c));
				read_word(sv[c].iq3, $sformatf("ch%0d iq3", c));
			end
		end
		read_word(last_ticks[15:0], "ticks low");
		read_word(last_ticks[31:16], "ticks mid");
		read_word(last_ticks[47:32], "ticks high");
		read_word(exp_ctr, "count word");
	endtask

	////////////////////
	// golden record player
	////////////////////

	task automatic run_record(input string rec);
		string                         kw;
		logic [31:0]                   v;
		logic [47:0]                   tk;
		logic [47:0]                   cs [`RX_CHANS];
		rx_buffer_pkg::rx_sample_vec_t sv;
		v = '0;
		void'($sscanf(rec, "%s", kw));
		if (kw == "test")
			void'($sscanf(rec, "%s %s", kw, test_name));
		else if (kw == "avail")
		begin
			if ($sscanf(rec, "%s %h %h %h %h %h", kw, tk, cs[0], cs[1], cs[2], cs[3]) != 6)
				stop_on_error($sformatf("golden avail record is malformed: %s", rec));
			for (int c = 0; c < `RX_CHANS; c++)
				sv[c] = cs[c];
			pulse_avail(tk, sv);
		end
		else if (kw == "reset")
			apply_reset();
		else
		begin
			void'($sscanf(rec, "%s %h", kw, v));
			if (kw == "nsamps")
				set_block_size(rx_buffer_pkg::rx_nsamps_t'(v));
			else if (kw == "block")
				read_block(rx_buffer_pkg::rx_word_t'(v));
			else if (kw == "ctr")
				read_ctr(rx_buffer_pkg::rx_word_t'(v));
			else if (kw == "srq")
				poll_srq(v[0]);
			else
				stop_on_error($sformatf("golden file has an unknown record: %s", rec));
		end
	endtask

	initial
	begin
		int    fd;
		int    n_avail;
		string line;
		n_avail       = 0;
		reset_bufs_A  = 1'b1;
		rx_avail_i    = 1'b0;
		samples_i     = '0;
		ticks_i       = '0;
		set_nsamps_i  = 1'b0;
		host_data_i   = '0;
		get_rx_srq_i  = 1'b0;
		get_rx_samp_i = 1'b0;
		get_buf_ctr_i = 1'b0;
		void'($urandom(32'h5f10574a));
		fd = $fopen("dv/rx_buffer_golden.txt", "r");
		if (fd == 0)
			stop_on_error("the golden file dv/rx_buffer_golden.txt could not be opened");
		while ($fgets(line, fd) != 0)
		begin
			if (line.len() > 1 && line.substr(0, 0) != "#")
			begin
				recs.push_back(line);
				if (line.substr(0, 4) == "avail")
					n_avail++;
			end
		end
		$fclose(fd);
		// gap and pulse per avail, reads of its 12 words, plus every other record
		limit_cycles = n_avail * (64 + 24) + recs.size() * 20 + 200;
		apply_reset();
		foreach (recs[k])
			run_record(recs[k]);
		if (n_errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

	// watchdog, armed once the record count is known
	initial
	begin
		wait (limit_cycles != 0);
		repeat (limit_cycles) @(posedge adc_clk);
		$display("timeout: the golden records did not finish within %0d cycles", limit_cycles);
		$display("Checks failed");
		$fatal(1, "watchdog expired");
	end

endmodule

// File: include/rx_buffer_consts.svh
/*
 * sizing constants for the shared rx sample buffer path
 * included by the package and by any module that needs a width or a count
 */
`ifndef RX_BUFFER_CONSTS_SVH
`define RX_BUFFER_CONSTS_SVH

// receiver channels interleaved into the buffer
`define RX_CHANS 4

`define RX_WORD_W 16			// buffer word width
`define RX_BUF_AW 13			// 8k words, reader may trail the writer by several blocks

`define RX_NSAMPS_W 7			// samples-per-block register width
`define RX_TICKS_W 48			// tick counter width, moved as three words

// i, q and iq3 per channel, and also the number of tick words
`define RX_WORDS_PER_CHAN 3

`endif

// File: run_sim.sh
#!/bin/sh
# build the rx buffer testbench with Verilator, run it and judge the log
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 -Wno-fatal --top-module rx_buffer_tb -f src.f -o rx_buffer_sim

# a stop by $fatal exits nonzero, the log decides the result
./obj_dir/rx_buffer_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Checks failed" sim.log; then
	echo "simulation failed, see sim.log"
	exit 1
fi
if ! grep -q "All checks passed" sim.log; then
	echo "simulation ended without a result, see sim.log"
	exit 1
fi
echo "simulation passed"

// File: src.f
+incdir+include
design/rx_buffer_pkg.sv
design/rx_xfer_fsm.sv
design/rx_word_mux.sv
design/rx_sample_buf.sv
design/rx_host_port.sv
design/rx_buffer_top.sv
dv/rx_buffer_tb.sv
